//--- aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  logic [31:0]            yValue,
    input  logic [31:0]            busValue,
    input  datapathPkg::opcodeT    aluOp,
    input  logic                   incPc,
    output datapathPkg::aluResultT result
);

    logic signed [63:0] product;
    logic signed [31:0] quotient;
    logic signed [31:0] remainder;
    logic               divZero;

    assign product = $signed(yValue) * $signed(busValue); // full signed product
    assign divZero = (busValue == '0);

    // divide by zero gives all ones and passes the dividend through as remainder
    assign quotient  = divZero ? 32'shFFFF_FFFF : $signed(yValue) / $signed(busValue);
    assign remainder = divZero ? $signed(yValue) : $signed(yValue) % $signed(busValue);

    always_comb begin
        result = '0;
        if (incPc) begin
            result.lo = busValue + 32'd4; // next PC during fetch
        end else begin
            case (aluOp)
                datapathPkg::add,
                datapathPkg::addi:  result.lo = yValue + busValue;
                datapathPkg::sub:   result.lo = yValue - busValue;
                datapathPkg::andOp: result.lo = yValue & busValue;
                datapathPkg::orOp:  result.lo = yValue | busValue;
                datapathPkg::shl:   result.lo = yValue << busValue[4:0];
                datapathPkg::shr:   result.lo = yValue >> busValue[4:0]; // logical
                datapathPkg::mul:   result = product;
                datapathPkg::div: begin
                    result.lo = quotient;
                    result.hi = remainder; // takes the sign of the dividend
                end
                default: result = '0; // nop
            endcase
        end
    end

endmodule

//--- busDatapath.sv
`timescale 1ns/10ps

module busDatapath (
    input  logic                   Clock,
    input  logic                   reset,
    input  controlPkg::axiLiteReqT axiReq,
    output controlPkg::axiLiteRspT axiRsp
);

    controlPkg::controlWordT ctrl;
    controlPkg::hostCmdT     cmd;
    logic                    start;
    logic                    busy;
    logic [31:0]             memData;
    logic [31:0]             busValue;
    logic [31:0]             regRead;
    logic [31:0]             immC;
    logic [31:0]             pcQ;
    logic [31:0]             mdrQ;
    logic [31:0]             yQ;
    logic [31:0]             hiQ;
    logic [31:0]             loQ;
    datapathPkg::instrWordT  irQ;
    datapathPkg::aluResultT  zQ;
    datapathPkg::aluResultT  aluResult;

    assign immC = {{13{irQ.iForm.imm[18]}}, irQ.iForm.imm};

    // the single shared bus carries one source per cycle
    always_comb begin
        case (ctrl.busSrc)
            controlPkg::busReg:   busValue = regRead;
            controlPkg::busPc:    busValue = pcQ;
            controlPkg::busMdr:   busValue = mdrQ;
            controlPkg::busZLow:  busValue = zQ.lo;
            controlPkg::busZHigh: busValue = zQ.hi;
            controlPkg::busHi:    busValue = hiQ;
            controlPkg::busLo:    busValue = loQ;
            controlPkg::busImmC:  busValue = immC;
            default:              busValue = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            pcQ  <= '0;
            mdrQ <= '0;
            irQ  <= '0;
            yQ   <= '0;
            zQ   <= '0;
            hiQ  <= '0;
            loQ  <= '0;
        end else begin
            if (ctrl.pcIn) pcQ <= busValue;
            if (ctrl.mdrIn) mdrQ <= ctrl.memRead ? memData : busValue;
            if (ctrl.irIn) irQ <= busValue;
            if (ctrl.yIn) yQ <= busValue;
            if (ctrl.zIn) zQ <= aluResult;
            if (ctrl.hiIn) hiQ <= busValue;
            if (ctrl.loIn) loQ <= busValue;
        end
    end

    hostRegs i_hostRegs (
        .Clock    (Clock),
        .reset    (reset),
        .axiReq   (axiReq),
        .busy     (busy),
        .mdrValue (mdrQ),
        .loValue  (loQ),
        .hiValue  (hiQ),
        .pcValue  (pcQ),
        .axiRsp   (axiRsp),
        .start    (start),
        .cmd      (cmd),
        .memData  (memData)
    );

    controlSequencer i_controlSequencer (
        .Clock   (Clock),
        .reset   (reset),
        .start   (start),
        .cmd     (cmd),
        .irValue (irQ),
        .ctrl    (ctrl),
        .busy    (busy)
    );

    registerFile i_registerFile (
        .Clock     (Clock),
        .reset     (reset),
        .regSel    (ctrl.regSel),
        .regIn     (ctrl.regIn),
        .busValue  (busValue),
        .readValue (regRead)
    );

    aluUnit i_aluUnit (
        .yValue   (yQ),
        .busValue (busValue),
        .aluOp    (ctrl.aluOp),
        .incPc    (ctrl.incPc),
        .result   (aluResult)
    );

endmodule

//--- busDatapath_assert.sv
`timescale 1ns/10ps

module busDatapathAssert (
    input logic                    Clock,
    input logic                    reset,
    input controlPkg::axiLiteReqT  axiReq,
    input controlPkg::axiLiteRspT  axiRsp,
    input logic                    busy,
    input controlPkg::controlWordT ctrl
);

    logic [3:0] busyCycles; // cycles busy has been high so far
    logic       anyEnable;

    assign anyEnable = ctrl.regIn | ctrl.pcIn | ctrl.incPc | ctrl.marIn | ctrl.mdrIn
                     | ctrl.memRead | ctrl.irIn | ctrl.yIn | ctrl.zIn | ctrl.loIn | ctrl.hiIn;

    always_ff @(posedge Clock) begin
        if (reset) begin
            busyCycles <= '0;
        end else if (busy) begin
            busyCycles <= busyCycles + 4'd1;
        end else begin
            busyCycles <= '0;
        end
    end

    bvalidHeld: assert property (@(posedge Clock) disable iff (reset)
        axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
        else $error("bvalid dropped before bready");

    rvalidHeld: assert property (@(posedge Clock) disable iff (reset)
        axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid)
        else $error("rvalid dropped before rready");

    // longest command is exec with T6, start cycle plus seven steps
    busyBounded: assert property (@(posedge Clock) disable iff (reset)
        busy |-> busyCycles < 4'd8)
        else $error("busy stayed high longer than 8 cycles");

    idleQuiet: assert property (@(posedge Clock) disable iff (reset)
        !busy |-> !anyEnable && ctrl.busSrc == controlPkg::busNone)
        else $error("control enable active while sequencer idle");

endmodule

bind busDatapath busDatapathAssert i_busDatapathAssert (
    .Clock  (Clock),
    .reset  (reset),
    .axiReq (axiReq),
    .axiRsp (axiRsp),
    .busy   (busy),
    .ctrl   (ctrl)
);

//--- compile.f
datapathPkg.sv
controlPkg.sv
registerFile.sv
aluUnit.sv
controlSequencer.sv
hostRegs.sv
busDatapath.sv
busDatapath_assert.sv
tbBusDatapath.sv

//--- controlPkg.sv
package controlPkg;

    typedef enum logic [3:0] {
        busNone,
        busReg,
        busPc,
        busMdr,
        busZLow,
        busZHigh,
        busHi,
        busLo,
        busImmC
    } busSrcT;

    // everything the datapath needs for one step
    typedef struct packed {
        busSrcT              busSrc;
        logic [3:0]          regSel;
        logic                regIn;
        logic                pcIn;
        logic                incPc;
        logic                marIn;
        logic                mdrIn;
        logic                memRead;  // MDR takes memData instead of the bus
        logic                irIn;
        logic                yIn;
        logic                zIn;
        logic                loIn;
        logic                hiIn;
        datapathPkg::opcodeT aluOp;
    } controlWordT;

    typedef enum logic [1:0] {
        cmdLoadReg = 2'd0,
        cmdExec    = 2'd1,
        cmdReadReg = 2'd2
    } cmdKindT;

    typedef struct packed {
        cmdKindT    kind;
        logic [3:0] regIdx;
    } hostCmdT;

    typedef struct packed {
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
    } axiLiteReqT;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
    } axiLiteRspT;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

endpackage

//--- controlSequencer.sv
`timescale 1ns/10ps

module controlSequencer (
    input  logic                    Clock,
    input  logic                    reset,
    input  logic                    start,
    input  controlPkg::hostCmdT     cmd,
    input  datapathPkg::instrWordT  irValue,
    output controlPkg::controlWordT ctrl,
    output logic                    busy
);

    typedef enum logic [3:0] {
        sIdle, sLoadMem, sLoadReg, sReadReg, sT0, sT1, sT2, sT3, sT4, sT5, sT6
    } stepT;

    stepT                step;
    stepT                stepNext;
    controlPkg::hostCmdT cmdQ;
    datapathPkg::opcodeT opcode;
    logic                wide;

    assign opcode = irValue.rForm.opcode;
    assign wide   = (opcode == datapathPkg::mul) || (opcode == datapathPkg::div); // needs T6
    assign busy   = start || (step != sIdle);

    always_ff @(posedge Clock) begin
        if (reset) begin
            step <= sIdle;
            cmdQ <= '0;
        end else begin
            step <= stepNext;
            if (start) begin
                cmdQ <= cmd; // regIdx is needed in the later steps
            end
        end
    end

    always_comb begin
        stepNext = sIdle;
        case (step)
            sIdle: begin
                if (start) begin
                    case (cmd.kind)
                        controlPkg::cmdLoadReg: stepNext = sLoadMem;
                        controlPkg::cmdExec:    stepNext = sT0;
                        controlPkg::cmdReadReg: stepNext = sReadReg;
                        default:                stepNext = sIdle;
                    endcase
                end
            end
            sLoadMem: stepNext = sLoadReg;
            sT0:      stepNext = sT1;
            sT1:      stepNext = sT2;
            sT2:      stepNext = sT3;
            sT3:      stepNext = sT4;
            sT4:      stepNext = sT5;
            sT5:      stepNext = wide ? sT6 : sIdle;
            default:  stepNext = sIdle; // sLoadReg, sReadReg and sT6 end here
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.busSrc = controlPkg::busNone;
        ctrl.aluOp  = datapathPkg::nop;
        case (step)
            sLoadMem: begin
                ctrl.memRead = 1'b1;
                ctrl.mdrIn   = 1'b1;
            end
            sLoadReg: begin
                ctrl.busSrc = controlPkg::busMdr;
                ctrl.regSel = cmdQ.regIdx;
                ctrl.regIn  = 1'b1;
            end
            sReadReg: begin
                ctrl.busSrc = controlPkg::busReg;
                ctrl.regSel = cmdQ.regIdx;
                ctrl.mdrIn  = 1'b1; // memRead low, so MDR takes the bus
            end
            sT0: begin
                ctrl.busSrc = controlPkg::busPc;
                ctrl.marIn  = 1'b1;
                ctrl.incPc  = 1'b1;
                ctrl.zIn    = 1'b1;
            end
            sT1: begin
                ctrl.busSrc  = controlPkg::busZLow;
                ctrl.pcIn    = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.mdrIn   = 1'b1;
            end
            sT2: begin
                ctrl.busSrc = controlPkg::busMdr;
                ctrl.irIn   = 1'b1;
            end
            sT3: begin
                ctrl.busSrc = controlPkg::busReg;
                ctrl.regSel = irValue.rForm.ra;
                ctrl.yIn    = 1'b1;
            end
            sT4: begin
                if (opcode == datapathPkg::addi) begin
                    ctrl.busSrc = controlPkg::busImmC;
                end else begin
                    ctrl.busSrc = controlPkg::busReg;
                    ctrl.regSel = irValue.rForm.rb;
                end
                ctrl.aluOp = opcode;
                ctrl.zIn   = 1'b1;
            end
            sT5: begin
                if (wide) begin
                    ctrl.busSrc = controlPkg::busZLow;
                    ctrl.loIn   = 1'b1;
                end else if (opcode != datapathPkg::nop) begin
                    ctrl.busSrc = controlPkg::busZLow;
                    // addi has no rc field, its result goes to rb
                    ctrl.regSel = (opcode == datapathPkg::addi) ? irValue.iForm.rb
                                                                : irValue.rForm.rc;
                    ctrl.regIn  = 1'b1;
                end
            end
            sT6: begin
                ctrl.busSrc = controlPkg::busZHigh;
                ctrl.hiIn   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- datapathPkg.sv
package datapathPkg;

    // opcode field values, mul and nop keep the classroom encodings
    typedef enum logic [4:0] {
        add   = 5'b00011,
        sub   = 5'b00100,
        andOp = 5'b00101,
        orOp  = 5'b00110,
        shr   = 5'b00111,
        shl   = 5'b01001,
        addi  = 5'b01100,
        nop   = 5'b01101,
        mul   = 5'b01111,
        div   = 5'b10000
    } opcodeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [3:0]  ra;       // first source
        logic [3:0]  rb;       // second source
        logic [3:0]  rc;       // destination
        logic [14:0] spare;
    } rFormT;

    typedef struct packed {
        opcodeT             opcode;
        logic [3:0]         ra;   // source
        logic [3:0]         rb;   // destination for addi
        logic signed [18:0] imm;  // sign-extended onto the bus as C
    } iFormT;

    typedef union packed {
        rFormT rForm;
        iFormT iForm;
    } instrWordT;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } aluResultT;

endpackage

//--- hostRegs.sv
`timescale 1ns/10ps

module hostRegs (
    input  logic                   Clock,
    input  logic                   reset,
    input  controlPkg::axiLiteReqT axiReq,
    input  logic                   busy,
    input  logic [31:0]            mdrValue,
    input  logic [31:0]            loValue,
    input  logic [31:0]            hiValue,
    input  logic [31:0]            pcValue,
    output controlPkg::axiLiteRspT axiRsp,
    output logic                   start,
    output controlPkg::hostCmdT    cmd,
    output logic [31:0]            memData
);

    localparam logic [31:0] addrMemData = 32'h00;
    localparam logic [31:0] addrCommand = 32'h04;
    localparam logic [31:0] addrStatus  = 32'h08;
    localparam logic [31:0] addrMdr     = 32'h0C;
    localparam logic [31:0] addrLo      = 32'h10;
    localparam logic [31:0] addrHi      = 32'h14;
    localparam logic [31:0] addrPc      = 32'h18;

    logic        bvalid;
    logic [1:0]  bresp;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        wrFire;
    logic        rdFire;
    logic        wrMem;
    logic        wrCmd;
    logic        rdHit;
    logic [31:0] rdValue;

    // address and data are taken in the same cycle, only when no response is pending
    assign wrFire = axiReq.awvalid && axiReq.wvalid && !bvalid;
    assign rdFire = axiReq.arvalid && !rvalid;
    assign wrMem  = (axiReq.awaddr == addrMemData);
    assign wrCmd  = (axiReq.awaddr == addrCommand) && !busy && (axiReq.wdata[1:0] != 2'b11);

    assign axiRsp.awready = wrFire;
    assign axiRsp.wready  = wrFire;
    assign axiRsp.bvalid  = bvalid;
    assign axiRsp.bresp   = bresp;
    assign axiRsp.arready = !rvalid;
    assign axiRsp.rvalid  = rvalid;
    assign axiRsp.rdata   = rdata;
    assign axiRsp.rresp   = rresp;

    always_comb begin
        rdHit   = 1'b1;
        rdValue = '0;
        case (axiReq.araddr)
            addrMemData: rdValue = memData;
            addrStatus:  rdValue = {31'b0, busy};
            addrMdr:     rdValue = mdrValue;
            addrLo:      rdValue = loValue;
            addrHi:      rdValue = hiValue;
            addrPc:      rdValue = pcValue;
            default:     rdHit = 1'b0; // Command is write only, it lands here too
        endcase
    end

    always_ff @(posedge Clock) begin
        if (reset) begin
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            start   <= 1'b0;
            memData <= '0;
        end else begin
            start <= wrFire && wrCmd; // one cycle after the handshake
            if (wrFire) begin
                bvalid <= 1'b1;
            end else if (bvalid && axiReq.bready) begin
                bvalid <= 1'b0;
            end
            if (rdFire) begin
                rvalid <= 1'b1;
            end else if (rvalid && axiReq.rready) begin
                rvalid <= 1'b0;
            end
            if (wrFire && wrMem) begin
                for (int b = 0; b < 4; b++) begin
                    if (axiReq.wstrb[b]) begin
                        memData[8*b +: 8] <= axiReq.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (wrFire) begin
            bresp <= (wrMem || wrCmd) ? controlPkg::respOkay : controlPkg::respSlvErr;
        end
        if (wrFire && wrCmd) begin
            cmd.kind   <= controlPkg::cmdKindT'(axiReq.wdata[1:0]);
            cmd.regIdx <= axiReq.wdata[7:4];
        end
        if (rdFire) begin
            rdata <= rdValue;
            rresp <= rdHit ? controlPkg::respOkay : controlPkg::respSlvErr;
        end
    end

endmodule

//--- registerFile.sv
`timescale 1ns/10ps

module registerFile (
    input  logic        Clock,
    input  logic        reset,
    input  logic [3:0]  regSel,
    input  logic        regIn,
    input  logic [31:0] busValue,
    output logic [31:0] readValue
);

    logic [31:0] regs [16]; // r0 to r15, r0 is an ordinary register here

    always_ff @(posedge Clock) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (regIn) begin
            regs[regSel] <= busValue; // bus lands in the selected register
        end
    end

    // the same select drives the read side, the top picks it when busSrc is reg
    assign readValue = regs[regSel];

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tbBusDatapath
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/VtbBusDatapath 2>&1)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOutput" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- tbBusDatapath.sv
`timescale 1ns/10ps

module tbBusDatapath;

    localparam logic [31:0] addrMemData = 32'h00;
    localparam logic [31:0] addrCommand = 32'h04;
    localparam logic [31:0] addrStatus  = 32'h08;
    localparam logic [31:0] addrMdr     = 32'h0C;
    localparam logic [31:0] addrLo      = 32'h10;
    localparam logic [31:0] addrHi      = 32'h14;
    localparam logic [31:0] addrPc      = 32'h18;
    localparam int          timeoutCycles = 40;

    logic                   Clock;
    logic                   reset;
    controlPkg::axiLiteReqT axiReq;
    controlPkg::axiLiteRspT axiRsp;
    logic [31:0]            lfsrState;
    logic [31:0]            expPc;     // PC the datapath should hold by now

    busDatapath i_busDatapath (
        .Clock  (Clock),
        .reset  (reset),
        .axiReq (axiReq),
        .axiRsp (axiRsp)
    );

    always #5 Clock = ~Clock;

    task automatic abortRun();
        $display("Finished with errors");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    // taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randWord(output logic [31:0] v);
        v = '0;
        for (int i = 0; i < 32; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]}; // one step per bit
        end
    endtask

    function automatic logic [31:0] rInstr(input datapathPkg::opcodeT op,
                                           input logic [3:0] ra, input logic [3:0] rb,
                                           input logic [3:0] rc);
        return {op, ra, rb, rc, 15'b0};
    endfunction

    function automatic logic [31:0] iInstr(input datapathPkg::opcodeT op,
                                           input logic [3:0] ra, input logic [3:0] rb,
                                           input logic [18:0] imm);
        return {op, ra, rb, imm};
    endfunction

    task automatic axiWrite(input logic [31:0] addr, input logic [31:0] data,
                            input int bDelay, output logic [1:0] resp);
        int waitCount;
        axiReq.awaddr  = addr;
        axiReq.wdata   = data;
        axiReq.wstrb   = 4'hF;
        axiReq.awvalid = 1'b1;
        axiReq.wvalid  = 1'b1;
        waitCount = 0;
        @(negedge Clock);
        while (!axiRsp.awready) begin
            waitCount++;
            if (waitCount > timeoutCycles) begin
                $display("timeout: write address and data never accepted");
                abortRun();
            end
            @(negedge Clock);
        end
        checkValue("wready", 32'(axiRsp.wready), 32'd1); // data goes with the address
        @(posedge Clock);
        #1;
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
        waitCount = 0;
        @(negedge Clock);
        while (!axiRsp.bvalid) begin
            waitCount++;
            if (waitCount > timeoutCycles) begin
                $display("timeout: no write response arrived");
                abortRun();
            end
            @(negedge Clock);
        end
        resp = axiRsp.bresp;
        repeat (bDelay) begin
            @(negedge Clock); // bready still low here
            checkValue("bvalid", 32'(axiRsp.bvalid), 32'd1);
        end
        @(posedge Clock);
        #1;
        axiReq.bready = 1'b1;
        @(posedge Clock);
        #1;
        axiReq.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [31:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int waitCount;
        axiReq.araddr  = addr;
        axiReq.arvalid = 1'b1;
        waitCount = 0;
        @(negedge Clock);
        while (!axiRsp.arready) begin
            waitCount++;
            if (waitCount > timeoutCycles) begin
                $display("timeout: read address never accepted");
                abortRun();
            end
            @(negedge Clock);
        end
        @(posedge Clock);
        #1;
        axiReq.arvalid = 1'b0;
        waitCount = 0;
        @(negedge Clock);
        while (!axiRsp.rvalid) begin
            waitCount++;
            if (waitCount > timeoutCycles) begin
                $display("timeout: no read data arrived");
                abortRun();
            end
            @(negedge Clock);
        end
        data = axiRsp.rdata;
        resp = axiRsp.rresp;
        @(posedge Clock);
        #1;
        axiReq.rready = 1'b1;
        @(posedge Clock);
        #1;
        axiReq.rready = 1'b0;
    endtask

    task automatic readOk(input logic [31:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axiRead(addr, data, resp);
        checkValue("rresp", 32'(resp), 32'(controlPkg::respOkay));
    endtask

    task automatic writeOk(input logic [31:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axiWrite(addr, data, 0, resp);
        checkValue("bresp", 32'(resp), 32'(controlPkg::respOkay));
    endtask

    task automatic waitIdle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        readOk(addrStatus, status);
        while (status[0]) begin
            polls++;
            if (polls > timeoutCycles) begin
                $display("timeout: sequencer stayed busy");
                abortRun();
            end
            readOk(addrStatus, status);
        end
    endtask

    task automatic issueCmd(input logic [1:0] kind, input logic [3:0] idx);
        writeOk(addrCommand, {24'b0, idx, 2'b00, kind});
        waitIdle();
    endtask

    task automatic loadReg(input logic [3:0] idx, input logic [31:0] value);
        writeOk(addrMemData, value);
        issueCmd(controlPkg::cmdLoadReg, idx);
    endtask

    task automatic readReg(input logic [3:0] idx, output logic [31:0] value);
        issueCmd(controlPkg::cmdReadReg, idx);
        readOk(addrMdr, value);
    endtask

    task automatic checkPc();
        logic [31:0] pc;
        readOk(addrPc, pc);
        checkValue("Pc", pc, expPc);
    endtask

    task automatic execInstr(input logic [31:0] instr);
        writeOk(addrMemData, instr); // fetch reads the instruction from memData
        issueCmd(controlPkg::cmdExec, 4'd0);
        expPc = expPc + 32'd4;
        checkPc();
    endtask

    task automatic testReset();
        logic [31:0] value;
        logic [1:0]  resp;
        readOk(addrStatus, value);
        checkValue("Status", value, 32'd0);
        readOk(addrLo, value);
        checkValue("Lo", value, 32'd0);
        readOk(addrHi, value);
        checkValue("Hi", value, 32'd0);
        readOk(addrPc, value);
        checkValue("Pc", value, 32'd0);
        readOk(addrMdr, value);
        checkValue("MdrValue", value, 32'd0);
        axiRead(32'h40, value, resp);
        checkValue("rresp", 32'(resp), 32'(controlPkg::respSlvErr));
        checkValue("rdata", value, 32'd0);
    endtask

    task automatic testLoadRead();
        logic [3:0]  idxList [4];
        logic [31:0] loaded [4];
        logic [31:0] value;
        idxList = '{4'd0, 4'd5, 4'd9, 4'd15};
        for (int i = 0; i < 4; i++) begin
            randWord(loaded[i]);
            loadReg(idxList[i], loaded[i]);
        end
        for (int i = 0; i < 4; i++) begin
            readReg(idxList[i], value); // all loaded first so no register could overwrite another
            checkValue("MdrValue", value, loaded[i]);
        end
    endtask

    task automatic testAluOps();
        datapathPkg::opcodeT ops [6];
        logic [31:0]         a;
        logic [31:0]         b;
        logic [31:0]         expected;
        logic [31:0]         value;
        ops = '{datapathPkg::add, datapathPkg::sub, datapathPkg::andOp,
                datapathPkg::orOp, datapathPkg::shl, datapathPkg::shr};
        for (int i = 0; i < 6; i++) begin
            randWord(a);
            randWord(b);
            loadReg(4'd1, a);
            loadReg(4'd2, b);
            execInstr(rInstr(ops[i], 4'd1, 4'd2, 4'(i + 4)));
            case (ops[i])
                datapathPkg::add:   expected = a + b;
                datapathPkg::sub:   expected = a - b;
                datapathPkg::andOp: expected = a & b;
                datapathPkg::orOp:  expected = a | b;
                datapathPkg::shl:   expected = a << b[4:0];
                default:            expected = a >> b[4:0];
            endcase
            readReg(4'(i + 4), value);
            checkValue("rc", value, expected);
        end
    endtask

    task automatic testAddi();
        logic [31:0] a;
        logic [31:0] r;
        logic [18:0] imm;
        logic [31:0] value;
        randWord(a);
        randWord(r);
        for (int i = 0; i < 2; i++) begin
            imm = (i == 0) ? 19'h7FB2E : {1'b1, r[17:0]}; // both negative
            loadReg(4'd6, a);
            execInstr(iInstr(datapathPkg::addi, 4'd6, 4'd7, imm));
            readReg(4'd7, value);
            checkValue("rb", value, a + {{13{imm[18]}}, imm});
        end
    endtask

    task automatic mulCheck(input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] product;
        logic [31:0]        value;
        product = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        loadReg(4'd1, a);
        loadReg(4'd2, b);
        execInstr(rInstr(datapathPkg::mul, 4'd1, 4'd2, 4'd0));
        readOk(addrLo, value);
        checkValue("Lo", value, product[31:0]);
        readOk(addrHi, value);
        checkValue("Hi", value, product[63:32]);
    endtask

    task automatic divCheck(input logic [31:0] a, input logic [31:0] b);
        logic [31:0] magA;
        logic [31:0] magB;
        logic [31:0] quotient;
        logic [31:0] remainder;
        logic [31:0] value;
        magA = a[31] ? -a : a;
        magB = b[31] ? -b : b;
        if (b == 32'd0) begin
            quotient  = 32'hFFFF_FFFF;
            remainder = a;
        end else begin
            quotient  = magA / magB; // magnitudes truncate toward zero
            remainder = magA % magB;
            if (a[31] ^ b[31]) begin
                quotient = -quotient;
            end
            if (a[31]) begin
                remainder = -remainder; // sign follows the dividend
            end
        end
        loadReg(4'd1, a);
        loadReg(4'd2, b);
        execInstr(rInstr(datapathPkg::div, 4'd1, 4'd2, 4'd0));
        readOk(addrLo, value);
        checkValue("Lo", value, quotient);
        readOk(addrHi, value);
        checkValue("Hi", value, remainder);
    endtask

    task automatic testMulDiv();
        logic [31:0] a;
        logic [31:0] b;
        mulCheck(32'h000F_0005, 32'h000F_0002);
        for (int i = 0; i < 3; i++) begin
            randWord(a);
            randWord(b);
            mulCheck(a, b);
            divCheck(a, {{16{b[15]}}, b[15:0]});
        end
        divCheck(32'hFFFF_FF85, 32'd7);
        divCheck(a, 32'd0);
    endtask

    task automatic testBusyAndBackPressure();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        logic [1:0]  resp;
        randWord(a);
        randWord(b);
        loadReg(4'd1, a);
        loadReg(4'd2, b);
        writeOk(addrMemData, rInstr(datapathPkg::add, 4'd1, 4'd2, 4'd3));
        writeOk(addrCommand, {24'b0, 4'd0, 2'b00, 2'(controlPkg::cmdExec)});
        // a loadReg of r3 here would overwrite the sum with the instruction word
        axiWrite(addrCommand, {24'b0, 4'd3, 2'b00, 2'(controlPkg::cmdLoadReg)}, 0, resp);
        checkValue("bresp", 32'(resp), 32'(controlPkg::respSlvErr));
        waitIdle();
        expPc = expPc + 32'd4;
        checkPc();
        readReg(4'd3, value);
        checkValue("rc", value, a + b);
        randWord(value);
        axiWrite(addrMemData, value, 6, resp);
        checkValue("bresp", 32'(resp), 32'(controlPkg::respOkay));
        readOk(addrMemData, a);
        checkValue("MemData", a, value);
    endtask

    initial begin
        Clock     = 1'b0;
        reset     = 1'b1;
        axiReq    = '0;
        lfsrState = 32'h38b5;
        expPc     = '0;
        repeat (3) @(posedge Clock);
        #1;
        reset = 1'b0;
        testReset();
        testLoadRead();
        testAluOps();
        testAddi();
        testMulDiv();
        testBusyAndBackPressure();
        $display("Finished with no errors");
        $finish;
    end

endmodule
